// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// frame geometry
	localparam int DATA_BITS      = 8;                       // payload width
	localparam int FRAME_BITS     = DATA_BITS + 3;           // start + data + parity + stop
	localparam int CLOCKS_PER_BIT = 8;                       // tx_clk cycles per bit on the line
	localparam int HALF_BIT       = CLOCKS_PER_BIT / 2;      // start bit centre offset
	localparam int SYNC_STAGES    = 3;                       // rx metastability chain depth

	// counter widths
	localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);      // holds 0 .. FRAME_BITS
	localparam int TICK_CNT_W = $clog2(CLOCKS_PER_BIT);      // holds 0 .. CLOCKS_PER_BIT-1

	// receiver state encoding
	localparam int          RX_STATE_W = 3;
	localparam logic [2:0]  RX_IDLE    = 3'd0;               // line idle, waiting for a low
	localparam logic [2:0]  RX_START   = 3'd1;               // half bit into the start bit
	localparam logic [2:0]  RX_DATA    = 3'd2;               // data bits, lsb first
	localparam logic [2:0]  RX_PARITY  = 3'd3;               // parity bit
	localparam logic [2:0]  RX_STOP    = 3'd4;               // stop bit, result goes out here

	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// Parity is always even: the parity bit is the xor of the eight data bits,
	// so data plus parity carries an even number of ones.
	typedef struct packed {
		logic       stop;                                    // msb, last on the line
		logic       parity;                                  // xor of data
		uart_byte_t data;                                    // bit 1 is data lsb
		logic       start;                                   // bit 0, first on the line
	} uart_frame_fields_t;

	// one frame word, loaded by field and shifted out as a raw vector
	typedef union packed {
		logic [FRAME_BITS-1:0] bits;                         // shift view, bit 0 goes out first
		uart_frame_fields_t    fields;                       // load view
	} uart_frame_u;

	// receive result, valid pulses for one cycle per frame
	typedef struct packed {
		uart_byte_t data;                                    // received byte, held between frames
		logic       valid;                                   // one-cycle strobe
		logic       error;                                   // parity or stop bit wrong
	} rx_result_t;

endpackage

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import uart_pkg::*;
(
	input  wire             tx_clk,
	input  wire             reset_tx,
	input  wire             i_enable,          // request strobe, honoured only when not busy
	input  wire uart_byte_t i_data,            // byte captured with the accepted enable
	output logic            o_busy,            // high from the cycle after accept to frame end
	output logic            o_serial_out       // registered line, idles high
);

	logic [TICK_CNT_W-1:0] tick_cnt;           // free-running baud divider
	logic                  tick;               // one cycle in every CLOCKS_PER_BIT
	logic                  accept;             // enable taken this cycle
	logic                  pending;            // frame loaded, waiting for a tick
	logic                  busy_q;             // frame owned by the transmitter
	logic                  frame_start;        // start bit goes onto the line next edge
	logic                  frame_done;         // last cycle of the stop bit
	logic [BIT_CNT_W-1:0]  bit_idx;            // bits put on the line so far, 0 when idle
	logic                  serial_q;           // line register
	uart_frame_u           frame_load;         // frame built from i_data
	uart_frame_u           frame_src;          // frame that starts at this tick
	uart_frame_u           shift_q;            // bits not yet on the line

	// baud tick, independent of traffic
	assign tick = (tick_cnt == TICK_CNT_W'(CLOCKS_PER_BIT - 1));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;                    // wrap
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// build the frame through the field view
	always_comb begin
		frame_load.fields.start  = 1'b0;
		frame_load.fields.data   = i_data;
		frame_load.fields.parity = ^i_data;    // even parity
		frame_load.fields.stop   = 1'b1;
	end

	assign accept      = i_enable && !o_busy;
	assign frame_done  = tick && (bit_idx == BIT_CNT_W'(FRAME_BITS));
	// an enable on a tick starts at once, otherwise it waits in shift_q
	assign frame_start = tick && (pending || accept);
	assign frame_src   = pending ? shift_q : frame_load;

	// busy drops for the last stop cycle so a new enable there
	// starts the next frame right on the following edge
	assign o_busy       = busy_q && !frame_done;
	assign o_serial_out = serial_q;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			busy_q  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (accept) begin
				busy_q <= 1'b1;
			end else if (frame_done) begin
				busy_q <= 1'b0;                // frame over, nothing queued
			end
			if (frame_start) begin
				pending <= 1'b0;
			end else if (accept) begin
				pending <= 1'b1;               // hold until the next tick
			end
		end
	end

	// bit index, 1 while the start bit is out, FRAME_BITS during stop
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			bit_idx <= '0;
		end else if (frame_start) begin
			bit_idx <= BIT_CNT_W'(1);
		end else if (frame_done) begin
			bit_idx <= '0;
		end else if (tick && (bit_idx != '0)) begin
			bit_idx <= bit_idx + 1'b1;
		end
	end

	// payload shift register
	always_ff @(posedge tx_clk) begin
		if (frame_start) begin
			shift_q.bits <= frame_src.bits >> 1;   // bit 0 goes to the line now
		end else if (accept) begin
			shift_q <= frame_load;                 // park until the tick
		end else if (tick && (bit_idx != '0)) begin
			shift_q.bits <= shift_q.bits >> 1;
		end
	end

	// line driver
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			serial_q <= 1'b1;                      // mark state
		end else if (frame_start) begin
			serial_q <= frame_src.bits[0];         // start bit
		end else if (frame_done) begin
			serial_q <= 1'b1;                      // back to idle
		end else if (tick && (bit_idx != '0)) begin
			serial_q <= shift_q.bits[0];           // data, parity, stop
		end
	end

	// idle line is always mark
	a_idle_line_high: assert property (@(posedge tx_clk) disable iff (reset_tx)
		!o_busy |-> o_serial_out)
		else $error("tx line low while not busy");

	// busy only falls a full frame after its start bit went out
	a_busy_full_frame: assert property (@(posedge tx_clk) disable iff (reset_tx)
		$fell(o_busy) |-> $past(frame_start, FRAME_BITS * CLOCKS_PER_BIT))
		else $error("tx busy fell before the frame was complete");

	a_tick_single: assert property (@(posedge tx_clk) disable iff (reset_tx)
		tick |=> !tick)
		else $error("baud tick high two cycles in a row");

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import uart_pkg::*;
(
	input  wire        tx_clk,
	input  wire        reset_tx,
	input  wire        i_serial_in,         // asynchronous line
	output rx_result_t o_rx                 // byte, one-cycle valid, error flag
);

	logic [SYNC_STAGES-1:0] sync_q;         // metastability chain
	logic                   rx_bit;         // synchronized line
	logic [RX_STATE_W-1:0]  state;
	logic [TICK_CNT_W-1:0]  tick_cnt;       // cycles inside the current bit
	logic [BIT_CNT_W-1:0]   bit_idx;        // data bits taken so far
	logic                   half_pt;        // centre of the start bit
	logic                   sample_pt;      // centre of data, parity and stop bits
	logic                   stop_sample;    // stop bit is sampled this cycle
	uart_byte_t             data_q;         // fills from the msb end
	logic                   parity_q;       // received parity bit
	rx_result_t             rx_q;

	// synchronizer, resets to mark so no false start after reset
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial_in};
		end
	end

	assign rx_bit = sync_q[SYNC_STAGES-1];

	assign half_pt     = (tick_cnt == TICK_CNT_W'(HALF_BIT - 1));
	assign sample_pt   = (tick_cnt == TICK_CNT_W'(CLOCKS_PER_BIT - 1));
	assign stop_sample = (state == RX_STOP) && sample_pt;

	// bit timing counter, cleared on every state change
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			tick_cnt <= '0;
		end else if ((state == RX_IDLE) || ((state == RX_START) && half_pt) || sample_pt) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// frame FSM
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state   <= RX_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					bit_idx <= '0;
					if (!rx_bit) begin
						state <= RX_START;       // falling edge of start bit
					end
				end
				RX_START: begin
					if (half_pt) begin
						// still high at mid start bit means a glitch
						state <= rx_bit ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample_pt) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == BIT_CNT_W'(DATA_BITS - 1)) begin
							state <= RX_PARITY;  // last data bit taken
						end
					end
				end
				RX_PARITY: begin
					if (sample_pt) begin
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample_pt) begin
						state <= RX_IDLE;        // ready for the next start edge
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// payload capture, lsb arrives first and walks down to bit 0
	always_ff @(posedge tx_clk) begin
		if ((state == RX_DATA) && sample_pt) begin
			data_q <= {rx_bit, data_q[DATA_BITS-1:1]};
		end
		if ((state == RX_PARITY) && sample_pt) begin
			parity_q <= rx_bit;
		end
	end

	// result register, data and error hold until the next frame
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			rx_q.valid <= 1'b0;
			rx_q.error <= 1'b0;
		end else begin
			rx_q.valid <= stop_sample;           // one-cycle strobe
			if (stop_sample) begin
				rx_q.data  <= data_q;
				// even parity mismatch or framing error
				rx_q.error <= (parity_q != ^data_q) || !rx_bit;
			end
		end
	end

	assign o_rx = rx_q;

	a_valid_single: assert property (@(posedge tx_clk) disable iff (reset_tx)
		rx_q.valid |=> !rx_q.valid)
		else $error("rx valid held longer than one cycle");

	a_bit_idx_range: assert property (@(posedge tx_clk) disable iff (reset_tx)
		bit_idx <= BIT_CNT_W'(DATA_BITS))
		else $error("rx bit index past the data field");

	// valid comes out of the stop state only, after all data bits were taken
	a_valid_from_stop: assert property (@(posedge tx_clk) disable iff (reset_tx)
		rx_q.valid |-> ($past(state) == RX_STOP) && ($past(bit_idx) == BIT_CNT_W'(DATA_BITS)))
		else $error("rx valid raised outside the stop state");

endmodule

`default_nettype wire

// ==== uart_loopback_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_top
	import uart_pkg::*;
(
	input  wire             tx_clk,
	input  wire             reset_tx,
	input  wire             i_enable,       // send strobe
	input  wire uart_byte_t i_data,         // byte to send
	input  wire             i_loopback,     // 1 = rx hears tx, 0 = rx hears i_serial_in
	input  wire             i_serial_in,    // external line, used for injected frames
	output logic            o_busy,
	output logic            o_serial_out,
	output rx_result_t      o_rx
);

	logic tx_line;                          // transmitter output
	logic rx_line;                          // line seen by the receiver

	uart_tx u_tx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_busy       (o_busy),
		.o_serial_out (tx_line)
	);

	assign o_serial_out = tx_line;

	// loopback select, level controlled
	assign rx_line = i_loopback ? tx_line : i_serial_in;

	uart_rx u_rx (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_serial_in (rx_line),
		.o_rx        (o_rx)
	);

endmodule

`default_nettype wire

// ==== uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_checker
	import uart_pkg::*;
(
	input  wire             tx_clk,
	input  wire             reset_tx,
	input  wire             i_enable,          // dut request strobe
	input  wire uart_byte_t i_data,            // dut request byte
	input  wire             i_busy,            // dut o_busy
	input  wire             i_serial,          // dut o_serial_out
	input  wire rx_result_t i_rx,              // dut o_rx
	input  wire             i_exp_push,        // queue i_exp this cycle
	input  wire rx_result_t i_exp,             // expected receive result
	input  wire             i_done,            // stimulus finished, report leftovers
	output int              o_value_errors,
	output int              o_event_errors,
	output int              o_pending          // expected results not yet seen
);

	localparam int BUSY_MIN = FRAME_BITS * CLOCKS_PER_BIT - 1;   // start latency of one cycle
	localparam int BUSY_MAX = BUSY_MIN + CLOCKS_PER_BIT - 1;     // start latency of a full bit

	uart_byte_t line_q [$];                    // accepted bytes not yet seen on the line
	rx_result_t exp_q [$];                     // receive results still to come
	int         line_value_errs = 0;
	int         line_event_errs = 0;
	int         busy_value_errs = 0;
	int         busy_event_errs = 0;
	int         rx_value_errs   = 0;
	int         rx_event_errs   = 0;
	int         pending         = 0;
	int         busy_len        = 0;           // cycles of the current busy period
	logic       accept_d        = 1'b0;        // enable accepted at the previous edge
	logic       b2b_d           = 1'b0;        // that accept came as busy fell
	logic       busy_prev       = 1'b0;
	logic       rx_done_seen    = 1'b0;

	assign o_value_errors = line_value_errs + busy_value_errs + rx_value_errs;
	assign o_event_errors = line_event_errs + busy_event_errs + rx_event_errs;
	assign o_pending      = pending;

	// line level of bit k of a frame: start, data lsb first, even parity, stop
	function automatic logic frame_bit(input uart_byte_t b, input int k);
		uart_byte_t s;
		if (k == 0) begin
			return 1'b0;
		end else if (k <= DATA_BITS) begin
			s = b >> (k - 1);
			return s[0];
		end else if (k == DATA_BITS + 1) begin
			return ^b;
		end
		return 1'b1;
	endfunction

	// reset state, busy rule, idle line
	always @(negedge tx_clk) begin
		if (reset_tx) begin
			if (i_busy !== 1'b0) begin
				$display("CHECK FAILED o_busy got %h expected 0 in reset at %0t", i_busy, $time);
				busy_value_errs++;
			end
			if (i_serial !== 1'b1) begin
				$display("CHECK FAILED o_serial_out got %h expected 1 in reset at %0t", i_serial, $time);
				busy_value_errs++;
			end
			if (i_rx.valid !== 1'b0) begin
				$display("CHECK FAILED o_rx.valid got %h expected 0 in reset at %0t", i_rx.valid, $time);
				busy_value_errs++;
			end
			busy_len  = 0;
			accept_d  = 1'b0;
			b2b_d     = 1'b0;
			busy_prev = 1'b0;
		end else begin
			if (accept_d && (i_busy !== 1'b1)) begin
				$display("CHECK FAILED o_busy got %h expected 1 after accept at %0t", i_busy, $time);
				busy_value_errs++;
			end
			if (b2b_d && (i_serial !== 1'b0)) begin   // no idle bit between frames
				$display("CHECK FAILED o_serial_out got %h expected 0 back to back at %0t",
					i_serial, $time);
				busy_value_errs++;
			end
			if (!i_busy && (i_serial !== 1'b1)) begin
				$display("CHECK FAILED o_serial_out got %h expected 1 while idle at %0t",
					i_serial, $time);
				busy_value_errs++;
			end
			if (i_busy) begin
				busy_len++;
			end else if (busy_len != 0) begin
				if ((busy_len < BUSY_MIN) || (busy_len > BUSY_MAX)) begin
					$display("o_busy stayed high for %0d cycles instead of %0d to %0d at %0t",
						busy_len, BUSY_MIN, BUSY_MAX, $time);
					busy_event_errs++;
				end
				busy_len = 0;
			end
			accept_d  = i_enable && !i_busy;
			b2b_d     = accept_d && busy_prev;
			busy_prev = i_busy;
		end
	end

	// frame shape on o_serial_out, sampled mid bit
	initial begin : line_watch
		logic prev;
		logic want;
		logic done_seen;
		uart_byte_t b;
		prev      = 1'b1;
		done_seen = 1'b0;
		forever begin
			@(negedge tx_clk);
			if (reset_tx) begin
				prev = 1'b1;
			end else begin
				if (i_enable && !i_busy) begin
					line_q.push_back(i_data);      // accepted at the coming edge
				end
				if (prev && !i_serial && i_busy) begin
					if (line_q.size() == 0) begin
						$display("tx line started a frame with no accepted byte at %0t", $time);
						line_event_errs++;
					end else begin
						b = line_q.pop_front();
						for (int k = 0; k < FRAME_BITS; k++) begin
							repeat ((k == 0) ? HALF_BIT : CLOCKS_PER_BIT) @(negedge tx_clk);
							want = frame_bit(b, k);
							if (i_serial !== want) begin
								$display("CHECK FAILED o_serial_out bit %0d got %h expected %h at %0t",
									k, i_serial, want, $time);
								line_value_errs++;
							end
						end
					end
				end
				prev = i_serial;
				if (i_done && !done_seen) begin
					if (line_q.size() != 0) begin
						$display("%0d accepted bytes never appeared on the tx line", line_q.size());
						line_event_errs += line_q.size();
					end
					done_seen = 1'b1;
				end
			end
		end
	end

	// receive results against the expected queue
	always @(negedge tx_clk) begin
		if (!reset_tx) begin
			if (i_exp_push) begin
				exp_q.push_back(i_exp);
			end
			if (i_rx.valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("unexpected receive valid pulse with data %h at %0t", i_rx.data, $time);
					rx_event_errs++;
				end else if (i_rx !== exp_q[0]) begin
					if (i_rx.data !== exp_q[0].data) begin
						$display("CHECK FAILED o_rx.data got %h expected %h at %0t",
							i_rx.data, exp_q[0].data, $time);
					end
					if (i_rx.error !== exp_q[0].error) begin
						$display("CHECK FAILED o_rx.error got %h expected %h at %0t",
							i_rx.error, exp_q[0].error, $time);
					end
					rx_value_errs++;
					exp_q.pop_front();
				end else begin
					exp_q.pop_front();             // match
				end
			end
			if (i_done && !rx_done_seen) begin
				if (exp_q.size() != 0) begin
					$display("%0d expected receive results never arrived", exp_q.size());
					rx_event_errs += exp_q.size();
				end
				rx_done_seen = 1'b1;
			end
			pending = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// ==== tb_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart
	import uart_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_ROWS     = 12;
	localparam int RESULT_WAIT  = 3 * FRAME_BITS * CLOCKS_PER_BIT;   // per row, in cycles
	localparam int WATCHDOG_NS  = NUM_ROWS * FRAME_BITS * CLOCKS_PER_BIT * CLK_PERIOD * 3
		+ RESET_CYCLES * CLK_PERIOD;

	typedef struct packed {
		logic       ext;                        // 1 = inject on i_serial_in, 0 = loopback send
		logic       use_lcg;                    // byte comes from the lcg
		uart_byte_t data;                       // fixed byte
		logic       bad_parity;                 // flip the parity bit
		logic       bad_stop;                   // drive the stop bit low
		logic       b2b;                        // second frame right behind the first
	} stim_row_t;

	logic        tx_clk   = 1'b0;
	logic        reset_tx = 1'b1;
	logic        i_enable;
	uart_byte_t  i_data;
	logic        i_loopback;
	logic        i_serial_in;
	logic        o_busy;
	logic        o_serial_out;
	rx_result_t  o_rx;
	logic        exp_push;
	rx_result_t  exp_value;
	logic        sim_done;
	int          value_errs;
	int          event_errs;
	int          pending;
	logic [31:0] lcg_state;
	stim_row_t   rows [NUM_ROWS];

	always #(CLK_PERIOD / 2) tx_clk = ~tx_clk;

	uart_loopback_top uut (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.i_loopback   (i_loopback),
		.i_serial_in  (i_serial_in),
		.o_busy       (o_busy),
		.o_serial_out (o_serial_out),
		.o_rx         (o_rx)
	);

	uart_checker u_checker (
		.tx_clk         (tx_clk),
		.reset_tx       (reset_tx),
		.i_enable       (i_enable),
		.i_data         (i_data),
		.i_busy         (o_busy),
		.i_serial       (o_serial_out),
		.i_rx           (o_rx),
		.i_exp_push     (exp_push),
		.i_exp          (exp_value),
		.i_done         (sim_done),
		.o_value_errors (value_errs),
		.o_event_errors (event_errs),
		.o_pending      (pending)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic step();
		@(posedge tx_clk);
		#1;                                     // inputs change just after the edge
	endtask

	task automatic expect_result(input uart_byte_t b, input logic err);
		exp_value.data  = b;
		exp_value.valid = 1'b1;
		exp_value.error = err;
		exp_push        = 1'b1;
		step();
		exp_push        = 1'b0;
	endtask

	task automatic send_byte(input uart_byte_t b);
		while (o_busy) begin
			step();
		end
		i_enable = 1'b1;
		i_data   = b;
		step();
		i_enable = 1'b0;
	endtask

	task automatic inject_frame(input uart_byte_t b, input logic bad_par, input logic bad_stop);
		logic [FRAME_BITS-1:0] frame;
		frame = {~bad_stop, (^b) ^ bad_par, b, 1'b0};   // stop, parity, data, start
		for (int k = 0; k < FRAME_BITS; k++) begin
			i_serial_in = frame[0];
			repeat (CLOCKS_PER_BIT) step();
			frame = frame >> 1;
		end
		i_serial_in = 1'b1;
		repeat (CLOCKS_PER_BIT) step();         // one idle bit so a low stop cannot look like a start
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while ((pending != 0) && (n < RESULT_WAIT)) begin
			step();
			n++;
		end
	endtask

	initial begin : stimulus
		stim_row_t  row;
		uart_byte_t first;
		uart_byte_t second;
		i_enable    = 1'b0;
		i_data      = '0;
		i_loopback  = 1'b1;
		i_serial_in = 1'b1;
		exp_push    = 1'b0;
		exp_value   = '0;
		sim_done    = 1'b0;
		lcg_state   = 32'h7e8a_43fc;
		// ext, use_lcg, data, bad_parity, bad_stop, b2b
		rows[0]  = '{1'b0, 1'b0, 8'h55, 1'b0, 1'b0, 1'b0};
		rows[1]  = '{1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0};
		rows[2]  = '{1'b0, 1'b0, 8'hff, 1'b0, 1'b0, 1'b0};
		rows[3]  = '{1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0};
		rows[4]  = '{1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b1};
		rows[5]  = '{1'b1, 1'b0, 8'h3c, 1'b0, 1'b0, 1'b0};
		rows[6]  = '{1'b1, 1'b0, 8'h81, 1'b1, 1'b0, 1'b0};
		rows[7]  = '{1'b1, 1'b1, 8'h00, 1'b0, 1'b1, 1'b0};
		rows[8]  = '{1'b1, 1'b0, 8'h7e, 1'b1, 1'b1, 1'b0};
		rows[9]  = '{1'b1, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0};
		rows[10] = '{1'b0, 1'b0, 8'ha5, 1'b0, 1'b0, 1'b1};
		rows[11] = '{1'b0, 1'b1, 8'h00, 1'b0, 1'b0, 1'b0};
		repeat (RESET_CYCLES) step();
		reset_tx = 1'b0;
		repeat (2 * CLOCKS_PER_BIT) step();     // quiet line after reset
		for (int r = 0; r < NUM_ROWS; r++) begin
			row   = rows[r];
			first = row.data;
			if (row.use_lcg) begin
				lcg_state = lcg_next(lcg_state);
				first     = lcg_state[23:16];
			end
			if (row.ext) begin
				i_loopback = 1'b0;
				expect_result(first, row.bad_parity | row.bad_stop);
				inject_frame(first, row.bad_parity, row.bad_stop);
			end else begin
				i_loopback = 1'b1;
				expect_result(first, 1'b0);
				if (row.b2b) begin
					lcg_state = lcg_next(lcg_state);
					second    = lcg_state[23:16];
					expect_result(second, 1'b0);
					send_byte(first);
					while (o_busy) begin
						step();
					end
					send_byte(second);          // enable in the cycle busy falls
				end else begin
					send_byte(first);
					repeat (3) step();
					i_enable = 1'b1;            // dropped, tx is mid frame
					i_data   = ~first;
					step();
					i_enable = 1'b0;
				end
			end
			wait_results();
		end
		sim_done = 1'b1;
		repeat (2) step();
		$display("errors: %0d wrong values, %0d missing or extra events", value_errs, event_errs);
		if ((value_errs == 0) && (event_errs == 0)) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_loopback.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_loopback_top.sv
uart_checker.sv
tb_uart.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_uart
FILELIST  = uart_loopback.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# the run passes only if the log holds the pass message
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
